// File: sd_share_pkg.sv
`default_nettype none

// shared types and defaults of the sd card sharing logic
package sd_share_pkg;

   //************************************************************************
   //* card lines of one controller
   //************************************************************************
   typedef struct packed {
      logic cs;        // chip select, active low on the card
      logic mosi;      // data to the card
      logic sclk;      // spi clock
   } spi_lines_t;

   //************************************************************************
   //* arbiter states
   //************************************************************************
   typedef enum logic [0:0] {
      ARB_IDLE  = 1'b0,   // card free, looking for a request
      ARB_OWNED = 1'b1    // one controller holds the card
   } arb_state_e;

   //************************************************************************
   //* defaults
   //************************************************************************
   // rk, dw, dm, dx, my
   localparam int DEF_CTRL_NUM = 5;

   // card lines when nobody owns the card
   localparam spi_lines_t DEF_IDLE_LINES = '{
      cs   : 1'b1,     // card deselected
      mosi : 1'b1,     // data line idles high
      sclk : 1'b0      // clock parked low
   };

endpackage

`default_nettype wire

// File: sd_grant_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// sd card access arbiter
// each request passes a two flop filter, the lowest index wins,
// an owner keeps the card until its own filtered request drops
module sd_grant_arbiter #(
   parameter int CTRL_NUM = 5           // number of sharing controllers
) (
   input  logic                sdclock,   // sd card clock domain
   input  logic                rst_n_i,   // sync reset, active low
   input  logic [CTRL_NUM-1:0] sd_req_i,  // access request levels
   output logic [CTRL_NUM-1:0] sd_gnt_o,  // access grants, one-hot or zero
   output logic [CTRL_NUM-1:0] led_n_o    // activity leds, active low
);

   //************************************************************************
   //* request filter
   //************************************************************************
   logic [CTRL_NUM-1:0] req_s0_q;          // first filter stage
   logic [CTRL_NUM-1:0] req_s1_q;          // second stage, filtered request

   always_ff @(posedge sdclock) begin
      if (!rst_n_i) begin
         req_s0_q <= '0;                    // no requests after reset
         req_s1_q <= '0;
      end else begin
         req_s0_q <= sd_req_i;              // sample raw levels
         req_s1_q <= req_s0_q;              // second sample
      end
   end

   //************************************************************************
   //* grant fsm
   //************************************************************************
   sd_share_pkg::arb_state_e state_q;      // current state
   sd_share_pkg::arb_state_e state_d;      // next state
   logic [CTRL_NUM-1:0]      gnt_q;        // registered grant
   logic [CTRL_NUM-1:0]      gnt_d;        // next grant
   logic [CTRL_NUM-1:0]      pick_gnt;     // lowest filtered request, one-hot
   logic                     any_req;      // some filtered request is up
   logic                     owner_req;    // owner still wants the card

   // priority pick, index 0 wins
   always_comb begin
      pick_gnt = '0;
      for (int i = CTRL_NUM - 1; i >= 0; i--) begin
         if (req_s1_q[i]) begin
            pick_gnt    = '0;               // drop the weaker candidate
            pick_gnt[i] = 1'b1;
         end
      end
   end

   assign any_req   = |req_s1_q;
   assign owner_req = |(req_s1_q & gnt_q);  // request of the grant holder

   always_comb begin
      state_d = state_q;                    // hold by default
      gnt_d   = gnt_q;
      case (state_q)
         sd_share_pkg::ARB_IDLE: begin
            if (any_req) begin
               gnt_d   = pick_gnt;          // new owner
               state_d = sd_share_pkg::ARB_OWNED;
            end
         end
         sd_share_pkg::ARB_OWNED: begin
            if (!owner_req) begin
               gnt_d   = '0;                // owner let go
               state_d = sd_share_pkg::ARB_IDLE;
            end
         end
         default: begin
            gnt_d   = '0;                   // unreachable, back to idle
            state_d = sd_share_pkg::ARB_IDLE;
         end
      endcase
   end

   always_ff @(posedge sdclock) begin
      if (!rst_n_i) begin
         state_q <= sd_share_pkg::ARB_IDLE;
         gnt_q   <= '0;                     // card free
      end else begin
         state_q <= state_d;
         gnt_q   <= gnt_d;
      end
   end

   assign sd_gnt_o = gnt_q;

   //************************************************************************
   //* activity leds
   //************************************************************************
   // lit while the filtered request is up
   assign led_n_o = ~req_s1_q;

   //************************************************************************
   //* assertions
   //************************************************************************
   // at most one controller on the card
   a_gnt_onehot0 : assert property (
      @(posedge sdclock) disable iff (!rst_n_i)
      $onehot0(sd_gnt_o)
   ) else $error("sd grant is not one-hot: %b", sd_gnt_o);

   // ownership passes only through an empty grant
   a_gnt_no_handover : assert property (
      @(posedge sdclock) disable iff (!rst_n_i)
      (|sd_gnt_o) |=> (sd_gnt_o == $past(sd_gnt_o)) || (sd_gnt_o == '0)
   ) else $error("sd grant moved between owners: %b -> %b",
                 $past(sd_gnt_o), sd_gnt_o);

endmodule

`default_nettype wire

// File: sd_line_mux.sv
`timescale 1ns/1ps
`default_nettype none

// sd card line multiplexer
// the granted controller drives the card, otherwise idle levels
module sd_line_mux #(
   parameter int                       CTRL_NUM   = 5,  // number of controllers
   parameter sd_share_pkg::spi_lines_t IDLE_LINES =
      sd_share_pkg::DEF_IDLE_LINES                      // levels with no owner
) (
   input  logic                                    sdclock,      // assertion clock
   input  logic                                    rst_n_i,      // assertion reset
   input  logic                     [CTRL_NUM-1:0] sd_gnt_i,     // grants from arbiter
   input  sd_share_pkg::spi_lines_t [CTRL_NUM-1:0] ctrl_lines_i, // lines per controller
   output sd_share_pkg::spi_lines_t                card_lines_o  // lines to the card
);

   localparam int LINE_W = $bits(sd_share_pkg::spi_lines_t);  // cs, mosi, sclk

   //************************************************************************
   //* and-or select
   //************************************************************************
   sd_share_pkg::spi_lines_t granted_lines;  // lines of the owner
   logic                     any_gnt;        // someone owns the card

   // grant is one-hot, so or-ing masked lines is a clean select
   always_comb begin
      granted_lines = '0;
      for (int k = 0; k < CTRL_NUM; k++) begin
         granted_lines = granted_lines | (ctrl_lines_i[k] & {LINE_W{sd_gnt_i[k]}});
      end
   end

   assign any_gnt = |sd_gnt_i;

   // no owner -> park the card
   assign card_lines_o = any_gnt ? granted_lines : IDLE_LINES;

   //************************************************************************
   //* assertions
   //************************************************************************
   // card stays deselected while the arbiter holds no grant
   a_idle_cs : assert property (
      @(posedge sdclock) disable iff (!rst_n_i)
      (sd_gnt_i == '0) |-> (card_lines_o.cs == IDLE_LINES.cs)
   ) else $error("card cs not idle without a grant");

endmodule

`default_nettype wire

// File: sd_share_top.sv
`timescale 1ns/1ps
`default_nettype none

// sd card sharing top
// arbiter picks the owner, mux routes its lines to the card
module sd_share_top #(
   parameter int CTRL_NUM = sd_share_pkg::DEF_CTRL_NUM  // sharing controllers
) (
   input  logic                                    sdclock,      // sd clock
   input  logic                                    rst_n_i,      // sync reset, active low
   input  logic                     [CTRL_NUM-1:0] sd_req_i,     // card requests
   input  sd_share_pkg::spi_lines_t [CTRL_NUM-1:0] ctrl_lines_i, // controller spi lines
   output logic                     [CTRL_NUM-1:0] sd_gnt_o,     // card grants
   output sd_share_pkg::spi_lines_t                sdcard_o,     // lines to the card
   output logic                     [CTRL_NUM-1:0] led_n_o       // activity leds
);

   logic [CTRL_NUM-1:0] gnt;               // arbiter -> mux and controllers

   //************************************************************************
   //* access arbiter
   //************************************************************************
   sd_grant_arbiter #(
      .CTRL_NUM (CTRL_NUM)
   ) sd_grant_arbiter_i (
      .sdclock  (sdclock),
      .rst_n_i  (rst_n_i),
      .sd_req_i (sd_req_i),                // raw request levels
      .sd_gnt_o (gnt),
      .led_n_o  (led_n_o)                  // follow filtered requests
   );

   //************************************************************************
   //* card line mux
   //************************************************************************
   sd_line_mux #(
      .CTRL_NUM   (CTRL_NUM),
      .IDLE_LINES (sd_share_pkg::DEF_IDLE_LINES)  // cs high, mosi high, sclk low
   ) sd_line_mux_i (
      .sdclock      (sdclock),
      .rst_n_i      (rst_n_i),
      .sd_gnt_i     (gnt),
      .ctrl_lines_i (ctrl_lines_i),
      .card_lines_o (sdcard_o)             // straight to the card pins
   );

   assign sd_gnt_o = gnt;                  // grants back to controllers

endmodule

`default_nettype wire

// File: sd_share_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sd_share_tb;

   localparam int         CTRL_NUM    = 5;       // rk, dw, dm, dx, my
   localparam int         CLK_PERIOD  = 40;      // ns
   localparam int         DRIVE_DELAY = 5;       // inputs change after the edge
   localparam int         MAX_LINES   = 256;     // bound on stimulus file length
   localparam logic [2:0] IDLE_EXP    = 3'b110;  // cs high, mosi high, sclk low

   logic                                    sdclock;
   logic                                    rst_n;
   logic                     [CTRL_NUM-1:0] sd_req;
   sd_share_pkg::spi_lines_t [CTRL_NUM-1:0] ctrl_lines;
   logic                     [CTRL_NUM-1:0] sd_gnt;
   sd_share_pkg::spi_lines_t                sdcard;
   logic                     [CTRL_NUM-1:0] led_n;

   integer              seed;                    // $random state
   integer              fd;                      // stimulus file handle
   int                  n_fields;
   int                  n_chars;
   int                  lines_read;
   int                  hold;
   int                  errors;
   int                  checks;
   int                  test_errors;
   int                  tests_run;
   int                  tests_passed;
   int                  tests_failed;
   logic [CTRL_NUM-1:0] req_hist;                // request level at the last edge
   logic [CTRL_NUM-1:0] prev_gnt;                // grant seen one cycle ago
   logic [CTRL_NUM-1:0] file_req;
   logic [CTRL_NUM-1:0] file_gnt;
   logic [CTRL_NUM-1:0] file_led;
   logic [8*24-1:0]     test_name;
   logic [8*160-1:0]    line_buf;

   //*************************************************************************
   //* clock and dut
   //*************************************************************************
   initial begin
      sdclock = 1'b0;
      forever #(CLK_PERIOD / 2) sdclock = ~sdclock;   // 25 MHz
   end

   sd_share_top #(
      .CTRL_NUM (CTRL_NUM)
   ) sd_share_top_i (
      .sdclock      (sdclock),
      .rst_n_i      (rst_n),
      .sd_req_i     (sd_req),
      .ctrl_lines_i (ctrl_lines),
      .sd_gnt_o     (sd_gnt),
      .sdcard_o     (sdcard),
      .led_n_o      (led_n)
   );

   //*************************************************************************
   //* helpers
   //*************************************************************************
   // owner's lines if one controller is granted, idle levels otherwise
   function automatic logic [2:0] expected_card(
      input logic                     [CTRL_NUM-1:0] gnt,
      input sd_share_pkg::spi_lines_t [CTRL_NUM-1:0] lines
   );
      logic [2:0] res;
      res = IDLE_EXP;
      for (int k = 0; k < CTRL_NUM; k++) begin
         if (gnt[k]) res = lines[k];
      end
      return res;
   endfunction

   function automatic bit is_onehot0(input logic [CTRL_NUM-1:0] v);
      int n;
      n = 0;
      for (int k = 0; k < CTRL_NUM; k++) begin
         if (v[k] === 1'b1) n++;                      // x counts as not set
      end
      return (n <= 1) && !$isunknown(v);
   endfunction

   task automatic report_error(input string msg);
      $display("error @ %0t ns: %0s", $time, msg);
      errors++;
      test_errors++;
   endtask

   task automatic drive_lines();
      logic [31:0] rnd;
      rnd        = $random(seed);
      ctrl_lines = rnd[3*CTRL_NUM-1:0];               // fresh spi lines every cycle
   endtask

   // one clock, then the per-cycle checks at edge + DRIVE_DELAY
   task automatic run_cycle();
      logic [CTRL_NUM-1:0] led_exp;
      logic [2:0]          card_exp;
      @(posedge sdclock);
      led_exp  = ~req_hist;                           // filter output lags two samples
      req_hist = sd_req;                              // level sampled at this edge
      #(DRIVE_DELAY);
      card_exp = expected_card(sd_gnt, ctrl_lines);
      checks++;
      if (led_n !== led_exp)
         report_error($sformatf("led_n %b, expected %b", led_n, led_exp));
      checks++;
      if (sdcard !== card_exp)
         report_error($sformatf("card lines %b with grant %b, expected %b",
                                sdcard, sd_gnt, card_exp));
      checks++;
      if (!is_onehot0(sd_gnt))
         report_error($sformatf("grant %b is not one-hot or zero", sd_gnt));
      checks++;
      if ((prev_gnt != '0) && (sd_gnt != '0) && (sd_gnt !== prev_gnt))
         report_error($sformatf("grant moved %b -> %b without release", prev_gnt, sd_gnt));
      prev_gnt = sd_gnt;
      drive_lines();                                  // still in the drive slot
   endtask

   // apply one request step, wait for its grant, then hold and check
   task automatic run_step(
      input int                  n_hold,
      input logic [CTRL_NUM-1:0] req,
      input logic [CTRL_NUM-1:0] gnt_exp,
      input logic [CTRL_NUM-1:0] led_exp
   );
      int waited;
      int limit;
      bit reached;
      test_errors = 0;
      waited      = 0;
      reached     = 0;
      // from a quiet idle a fresh grant arrives 3 cycles after the request
      if ((sd_gnt == '0) && (req_hist == '0) && (gnt_exp != '0)) limit = 3;
      else limit = n_hold;
      sd_req = req;
      while (!reached && (waited < limit)) begin
         run_cycle();
         waited++;
         if (sd_gnt === gnt_exp) reached = 1;
      end
      if (!reached) begin
         $display("timeout: grant stayed at %b instead of %b after %0d cycles",
                  sd_gnt, gnt_exp, waited);
         errors++;
         test_errors++;
      end
      while (waited < n_hold) begin
         run_cycle();
         waited++;
      end
      checks++;
      if (sd_gnt !== gnt_exp)
         report_error($sformatf("grant %b at end of hold, expected %b", sd_gnt, gnt_exp));
      checks++;
      if (led_n !== led_exp)
         report_error($sformatf("led_n %b at end of hold, expected %b", led_n, led_exp));
      tests_run++;
      if (test_errors == 0) begin
         tests_passed++;
         $display("test %0s: pass", test_name);
      end else begin
         tests_failed++;
         $display("test %0s: fail, %0d errors", test_name, test_errors);
      end
   endtask

   //*************************************************************************
   //* main sequence
   //*************************************************************************
   initial begin
      rst_n        = 1'b0;                            // reset from time zero
      sd_req       = '0;
      ctrl_lines   = '0;
      seed         = 32'hd09e;
      req_hist     = '0;
      prev_gnt     = '0;
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_passed = 0;
      tests_failed = 0;
      lines_read   = 0;
      repeat (4) @(posedge sdclock);                  // 4 cycles in reset
      #(DRIVE_DELAY);
      rst_n = 1'b1;

      fd = $fopen("sd_share_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open stimulus file sd_share_stimulus.txt");
         $display("CHECKS FAILED");
         $finish;
      end else begin
         while (!$feof(fd) && (lines_read < MAX_LINES)) begin
            line_buf  = '0;
            test_name = '0;
            n_chars   = $fgets(line_buf, fd);
            lines_read++;
            if (n_chars == 0)
               n_fields = 0;                          // nothing left to read
            else
               n_fields = $sscanf(line_buf, "%s %b %d %b %b",
                                  test_name, file_req, hold, file_gnt, file_led);
            if (n_fields == 5) begin                  // comments and blanks fall out
               if (hold < 4) begin
                  $display("stimulus step %0s has a hold shorter than 4 cycles", test_name);
                  errors++;
               end
               run_step(hold, file_req, file_gnt, file_led);
            end
         end
         $fclose(fd);
         if (tests_run == 0) begin
            $display("no test steps found in the stimulus file");
            errors++;
         end
         $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                  tests_run, tests_passed, tests_failed, checks, errors);
         if (errors == 0) begin
            $display("ALL CHECKS PASSED");
         end else begin
            $display("CHECKS FAILED");
         end
         $finish;
      end
   end

   // last resort against a stuck run
   initial begin
      #(CLK_PERIOD * 4000);
      $display("simulation did not finish in time");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: sd_share_stimulus.txt
# columns: test name, request vector (controller 4..0), hold cycles,
#          expected grant at end of hold, expected led_n at end of hold
# controllers: 0 rk, 1 dw, 2 dm, 3 dx, 4 my

# reset state, nothing requested
reset_idle       00000 4 00000 11111

# single requests, grant from idle and line routing
single_rk        00001 5 00001 11110
release_rk       00000 4 00000 11111
single_dx        01000 6 01000 10111
release_dx       00000 4 00000 11111
single_my        10000 5 10000 01111
release_my       00000 4 00000 11111

# several requests rise together, lowest index wins
priority_all     11111 6 00001 00000
release_all      00000 5 00000 11111
priority_pair    10110 6 00010 01001
release_pair     00000 5 00000 11111

# low priority owner keeps the card
owner_my         10000 5 10000 01111
preempt_try_rk   10001 6 10000 01110
preempt_try_dw   10011 6 10000 01100
handover_rk      00011 6 00001 11100
handover_dw      00010 6 00010 11101
release_dw       00000 5 00000 11111

# middle owner against everyone else
owner_dm         00100 5 00100 11011
dm_keeps_all     11111 6 00100 00000
dm_drops         11011 6 00001 00100

# final release, card idle and leds dark
release_final    00000 5 00000 11111

// File: sd_share_top.f
sd_share_pkg.sv
sd_grant_arbiter.sv
sd_line_mux.sv
sd_share_top.sv
sd_share_tb.sv
